// File: include/attack_defines.svh
`ifndef ATTACK_DEFINES_SVH
`define ATTACK_DEFINES_SVH

// board geometry
`define BOARD_SQUARES 64
`define BOARD_SIDE    8

// width of one encoded piece
`define PIECE_BITS    4

// sliding directions, four orthogonal and four diagonal
`define RAY_COUNT     8

`endif

// File: design/attack_pkg.sv
`include "attack_defines.svh"

package attack_pkg;

   // bit 3 set marks a black piece
   typedef enum logic [`PIECE_BITS-1:0] {
      empty_sq = 4'd0,
      w_pawn   = 4'd1,
      w_knight = 4'd2,
      w_bishop = 4'd3,
      w_rook   = 4'd4,
      w_queen  = 4'd5,
      w_king   = 4'd6,
      b_pawn   = 4'd9,
      b_knight = 4'd10,
      b_bishop = 4'd11,
      b_rook   = 4'd12,
      b_queen  = 4'd13,
      b_king   = 4'd14
   } piece_e;

   typedef enum logic {
      side_white = 1'b0,
      side_black = 1'b1
   } side_e;

   typedef enum logic [2:0] {
      kind_none   = 3'd0,
      kind_pawn   = 3'd1,
      kind_knight = 3'd2,
      kind_bishop = 3'd3,
      kind_rook   = 3'd4,
      kind_queen  = 3'd5,
      kind_king   = 3'd6
   } kind_e;

   // row * 8 + col, row 0 is the white home rank
   typedef logic [5:0] square_t;

   typedef piece_e [`BOARD_SQUARES-1:0] board_t;

   typedef struct packed {
      logic    valid;
      board_t  board;
      square_t target;
      side_e   side;
   } query_t;

   typedef struct packed {
      logic  occupied;
      kind_e kind;
   } square_info_t;

   typedef square_info_t [`BOARD_SQUARES-1:0] board_info_t;

   typedef struct packed {
      logic    valid;
      square_t target;
      side_e   side;
      logic    target_own;
   } stage_t;

   // n, s, e, w, ne, nw, se, sw
   localparam int RAY_ROW_STEP [`RAY_COUNT] = '{1, -1, 0, 0, 1, 1, -1, -1};
   localparam int RAY_COL_STEP [`RAY_COUNT] = '{0, 0, 1, -1, 1, -1, 1, -1};

   function automatic logic on_board(int row, int col);
      return (row >= 0) && (row < `BOARD_SIDE) && (col >= 0) && (col < `BOARD_SIDE);
   endfunction

   // kind of the piece if it belongs to side s, none otherwise
   function automatic kind_e attacker_kind(piece_e p, side_e s);
      logic [`PIECE_BITS-1:0] code;
      kind_e                  kind;
      code = p;
      case (code[2:0])
         3'd1:    kind = kind_pawn;
         3'd2:    kind = kind_knight;
         3'd3:    kind = kind_bishop;
         3'd4:    kind = kind_rook;
         3'd5:    kind = kind_queen;
         3'd6:    kind = kind_king;
         default: kind = kind_none;
      endcase
      if (code[3] != logic'(s))
         kind = kind_none;
      return kind;
   endfunction

endpackage

// File: design/square_classifier.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module square_classifier
   import attack_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n_i,
   input  query_t      query_i,
   output board_info_t board_info_o,
   output stage_t      stage_o
);

   board_info_t info_d;
   logic        own_d;

   logic        valid_q;
   square_t     target_q;
   side_e       side_q;
   logic        own_q;

   always_comb
   begin
      for (int sq = 0; sq < `BOARD_SQUARES; sq++)
      begin
         info_d[sq].occupied = (query_i.board[sq] != empty_sq);
         info_d[sq].kind     = attacker_kind(query_i.board[sq], query_i.side);
      end
      // attacker's own piece on the target
      own_d = (info_d[query_i.target].kind != kind_none);
   end

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         valid_q <= 1'b0;
      else
         valid_q <= query_i.valid;
   end

   always_ff @(posedge clk)
   begin
      board_info_o <= info_d;
      target_q     <= query_i.target;
      side_q       <= query_i.side;
      own_q        <= own_d;
   end

   assign stage_o = '{valid: valid_q, target: target_q, side: side_q, target_own: own_q};

endmodule

// File: design/ray_scanner.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module ray_scanner
   import attack_pkg::*;
#(
   parameter int DIR = 0
)
(
   input  logic        clk,
   input  board_info_t board_info_i,
   input  stage_t      stage_i,
   output logic        ray_hit_o
);

   localparam int DR = RAY_ROW_STEP[DIR];
   localparam int DC = RAY_COL_STEP[DIR];

   // rook lines first, then the diagonals
   localparam kind_e SLIDER = (DIR < 4) ? kind_rook : kind_bishop;

   logic hit_d;

   always_comb
   begin
      int           row0;
      int           col0;
      int           r;
      int           c;
      logic         blocked;
      square_info_t sq;

      hit_d   = 1'b0;
      blocked = 1'b0;
      row0    = int'(stage_i.target) / `BOARD_SIDE;
      col0    = int'(stage_i.target) % `BOARD_SIDE;
      sq      = '0;

      // walk outward, first occupied square decides
      for (int step = 1; step < `BOARD_SIDE; step++)
      begin
         r = row0 + step * DR;
         c = col0 + step * DC;
         if (on_board(r, c) && !blocked)
         begin
            sq = board_info_i[r * `BOARD_SIDE + c];
            if (sq.occupied)
            begin
               blocked = 1'b1;
               hit_d   = (sq.kind == SLIDER) || (sq.kind == kind_queen);
            end
         end
      end
   end

   always_ff @(posedge clk)
   begin
      ray_hit_o <= hit_d;
   end

endmodule

// File: design/leaper_checker.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module leaper_checker
   import attack_pkg::*;
(
   input  logic        clk,
   input  board_info_t board_info_i,
   input  stage_t      stage_i,
   output logic        leap_hit_o
);

   localparam int KNIGHT_ROW_STEP [8] = '{-1, -2, -2, -1, 1, 2, 2, 1};
   localparam int KNIGHT_COL_STEP [8] = '{-2, -1, 1, 2, 2, 1, -1, -2};

   logic hit_d;

   always_comb
   begin
      int row0;
      int col0;
      int r;
      int c;
      int pawn_dr;

      hit_d = 1'b0;
      row0  = int'(stage_i.target) / `BOARD_SIDE;
      col0  = int'(stage_i.target) % `BOARD_SIDE;

      for (int k = 0; k < 8; k++)
      begin
         r = row0 + KNIGHT_ROW_STEP[k];
         c = col0 + KNIGHT_COL_STEP[k];
         if (on_board(r, c) && (board_info_i[r * `BOARD_SIDE + c].kind == kind_knight))
            hit_d = 1'b1;

         // king neighbours reuse the ray steps, all eight of them
         r = row0 + RAY_ROW_STEP[k];
         c = col0 + RAY_COL_STEP[k];
         if (on_board(r, c) && (board_info_i[r * `BOARD_SIDE + c].kind == kind_king))
            hit_d = 1'b1;
      end

      // white pawns capture upward, so they sit one row below
      pawn_dr = (stage_i.side == side_white) ? -1 : 1;
      r       = row0 + pawn_dr;
      for (int dc = -1; dc <= 1; dc += 2)
      begin
         c = col0 + dc;
         if (on_board(r, c) && (board_info_i[r * `BOARD_SIDE + c].kind == kind_pawn))
            hit_d = 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      leap_hit_o <= hit_d;
   end

endmodule

// File: design/attack_merge.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module attack_merge
   import attack_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n_i,
   input  stage_t                stage_i,
   input  logic [`RAY_COUNT-1:0] ray_hits_i,
   input  logic                  leap_hit_i,
   output logic                  attacked_o,
   output logic                  attacked_valid_o
);

   logic valid_q;
   logic own_q;
   logic any_hit;

   assign any_hit = (|ray_hits_i) | leap_hit_i;

   always_ff @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_q          <= 1'b0;
         attacked_valid_o <= 1'b0;
         attacked_o       <= 1'b0;
      end
      else
      begin
         valid_q          <= stage_i.valid;
         attacked_valid_o <= valid_q;
         // own piece on the target is never attacked
         attacked_o       <= valid_q & ~own_q & any_hit;
      end
   end

   always_ff @(posedge clk)
   begin
      own_q <= stage_i.target_own;
   end

endmodule

// File: design/square_attack_top.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module square_attack_top
   import attack_pkg::*;
(
   input  logic   clk,
   input  logic   arst_n_i,
   input  query_t query_i,
   output logic   attacked_o,
   output logic   attacked_valid_o
);

   board_info_t           board_info;
   stage_t                stage;
   logic [`RAY_COUNT-1:0] ray_hits;
   logic                  leap_hit;

   square_classifier i_classifier (
      .clk          (clk),
      .arst_n_i     (arst_n_i),
      .query_i      (query_i),
      .board_info_o (board_info),
      .stage_o      (stage)
   );

   // one scanner per direction
   generate
      for (genvar d = 0; d < `RAY_COUNT; d++)
      begin : g_ray
         ray_scanner #(
            .DIR (d)
         ) i_ray (
            .clk          (clk),
            .board_info_i (board_info),
            .stage_i      (stage),
            .ray_hit_o    (ray_hits[d])
         );
      end
   endgenerate

   leaper_checker i_leaper (
      .clk          (clk),
      .board_info_i (board_info),
      .stage_i      (stage),
      .leap_hit_o   (leap_hit)
   );

   attack_merge i_merge (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .stage_i          (stage),
      .ray_hits_i       (ray_hits),
      .leap_hit_i       (leap_hit),
      .attacked_o       (attacked_o),
      .attacked_valid_o (attacked_valid_o)
   );

endmodule

// File: tests/tb_square_attack.sv
`timescale 1ns/1ps
`include "attack_defines.svh"

module tb_square_attack
   import attack_pkg::*;
();

   localparam int DIRECTED_QUERIES = 24;
   localparam int STREAM_QUERIES   = 200;
   localparam int WATCHDOG_CYCLES  = (DIRECTED_QUERIES + STREAM_QUERIES) * 3 + 200;

   // n, s, e, w, then the diagonals
   localparam int LINE_DR [8] = '{1, -1, 0, 0, 1, 1, -1, -1};
   localparam int LINE_DC [8] = '{0, 0, 1, -1, 1, -1, 1, -1};
   localparam int JUMP_DR [8] = '{1, 2, 2, 1, -1, -2, -2, -1};
   localparam int JUMP_DC [8] = '{2, 1, -1, -2, -2, -1, 1, 2};
   localparam piece_e PIECE_SET [12] = '{w_pawn, w_knight, w_bishop, w_rook, w_queen, w_king,
                                         b_pawn, b_knight, b_bishop, b_rook, b_queen, b_king};

   logic       clk;
   logic       arst_n_i;
   query_t     query_i;
   logic       attacked_o;
   logic       attacked_valid_o;

   board_t     bd;
   integer     seed;
   int         queries_sent;
   int         answers_seen;
   logic [2:0] exp_valid;
   logic [2:0] exp_attacked;

   square_attack_top i_dut (
      .clk              (clk),
      .arst_n_i         (arst_n_i),
      .query_i          (query_i),
      .attacked_o       (attacked_o),
      .attacked_valid_o (attacked_valid_o)
   );

   always #50 clk = ~clk;

   function automatic logic in_range(int r, int c);
      return (r >= 0) && (r < `BOARD_SIDE) && (c >= 0) && (c < `BOARD_SIDE);
   endfunction

   function automatic square_t square_at(int r, int c);
      return square_t'(r * `BOARD_SIDE + c);
   endfunction

   // kind of a piece owned by side s, none otherwise
   function automatic kind_e side_kind(piece_e p, side_e s);
      kind_e k;
      logic  black;
      black = (p >= b_pawn);
      case (p)
         w_pawn,   b_pawn:   k = kind_pawn;
         w_knight, b_knight: k = kind_knight;
         w_bishop, b_bishop: k = kind_bishop;
         w_rook,   b_rook:   k = kind_rook;
         w_queen,  b_queen:  k = kind_queen;
         w_king,   b_king:   k = kind_king;
         default:            k = kind_none;
      endcase
      if (black != (s == side_black))
         k = kind_none;
      return k;
   endfunction

   // reference answer straight from the chess rules
   function automatic logic expected_attack(board_t b, square_t t, side_e s);
      int    row;
      int    col;
      int    r;
      int    c;
      logic  hit;
      logic  stop;
      kind_e kd;
      row = int'(t) / `BOARD_SIDE;
      col = int'(t) % `BOARD_SIDE;
      hit = 1'b0;
      if (side_kind(b[t], s) != kind_none)
         return 1'b0;
      for (int d = 0; d < 8; d++)
      begin
         stop = 1'b0;
         for (int k = 1; k < `BOARD_SIDE; k++)
         begin
            r = row + k * LINE_DR[d];
            c = col + k * LINE_DC[d];
            if (!stop && in_range(r, c) && (b[square_at(r, c)] != empty_sq))
            begin
               stop = 1'b1;
               kd   = side_kind(b[square_at(r, c)], s);
               if (kd == kind_queen || kd == ((d < 4) ? kind_rook : kind_bishop))
                  hit = 1'b1;
            end
         end
         r = row + LINE_DR[d];
         c = col + LINE_DC[d];
         if (in_range(r, c) && side_kind(b[square_at(r, c)], s) == kind_king)
            hit = 1'b1;
         r = row + JUMP_DR[d];
         c = col + JUMP_DC[d];
         if (in_range(r, c) && side_kind(b[square_at(r, c)], s) == kind_knight)
            hit = 1'b1;
      end
      // white pawns capture toward higher rows
      r = (s == side_white) ? row - 1 : row + 1;
      for (int dc = -1; dc <= 1; dc += 2)
      begin
         if (in_range(r, col + dc) && side_kind(b[square_at(r, col + dc)], s) == kind_pawn)
            hit = 1'b1;
      end
      return hit;
   endfunction

   task automatic abort_run(string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_attacked(logic expected, logic actual);
      if (actual !== expected)
         abort_run($sformatf("mismatch at %0t: attacked_o expected %b actual %b",
                             $time, expected, actual));
   endtask

   task automatic check_valid(logic expected, logic actual);
      if (expected === 1'b1 && actual !== 1'b1)
         abort_run($sformatf("no answer strobe at %0t, three cycles after a query", $time));
      else if (expected !== 1'b1 && actual !== 1'b0)
         abort_run($sformatf("answer strobe at %0t without a query three cycles earlier",
                             $time));
   endtask

   // expected answers ride along with the fixed latency
   always @(posedge clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         exp_valid    <= '0;
         exp_attacked <= '0;
      end
      else
      begin
         exp_valid    <= {exp_valid[1:0], query_i.valid};
         exp_attacked <= {exp_attacked[1:0],
                          expected_attack(query_i.board, query_i.target, query_i.side)};
      end
   end

   always @(negedge clk)
   begin
      check_valid(exp_valid[2], attacked_valid_o);
      if (exp_valid[2])
      begin
         check_attacked(exp_attacked[2], attacked_o);
         answers_seen++;
      end
   end

   initial
   begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      abort_run($sformatf("simulation timed out after %0d cycles", WATCHDOG_CYCLES));
   end

   task automatic clear_board();
      for (int i = 0; i < `BOARD_SQUARES; i++)
         bd[i] = empty_sq;
   endtask

   task automatic place(int r, int c, piece_e p);
      bd[square_at(r, c)] = p;
   endtask

   task automatic send_query(board_t b, square_t t, side_e s);
      @(negedge clk);
      query_i.valid  = 1'b1;
      query_i.board  = b;
      query_i.target = t;
      query_i.side   = s;
      queries_sent++;
   endtask

   // one query on the current board, hand-derived answer
   task automatic check_single(int tr, int tc, side_e s, logic expected);
      square_t t;
      t = square_at(tr, tc);
      if (expected_attack(bd, t, s) !== expected)
         abort_run($sformatf("reference model disagrees with the directed answer, square %0d",
                             t));
      send_query(bd, t, s);
      @(negedge clk);
      query_i.valid = 1'b0;
      while (attacked_valid_o !== 1'b1)
         @(negedge clk);
      check_attacked(expected, attacked_o);
   endtask

   task automatic test_reset_idle();
      repeat (5)
      begin
         @(negedge clk);
         check_valid(1'b0, attacked_valid_o);
      end
      arst_n_i = 1'b1;
      repeat (8)
      begin
         @(negedge clk);
         check_valid(1'b0, attacked_valid_o);
      end
   endtask

   task automatic test_sliders();
      clear_board();
      place(3, 0, w_rook);
      check_single(3, 4, side_white, 1'b1);
      place(3, 2, b_pawn);
      check_single(3, 4, side_white, 1'b0);
      clear_board();
      place(0, 1, w_bishop);
      check_single(3, 4, side_white, 1'b1);
      clear_board();
      place(7, 4, w_queen);
      check_single(3, 4, side_white, 1'b1);
      place(5, 4, w_knight);
      check_single(3, 4, side_white, 1'b0);
      clear_board();
      place(6, 7, w_queen);
      check_single(3, 4, side_white, 1'b1);
      clear_board();
      place(3, 0, b_rook);
      check_single(3, 4, side_white, 1'b0);
      clear_board();
      place(0, 1, w_rook);
      check_single(3, 4, side_white, 1'b0);
   endtask

   task automatic test_leapers();
      clear_board();
      place(1, 3, w_knight);
      check_single(3, 4, side_white, 1'b1);
      clear_board();
      place(1, 4, w_knight);
      check_single(3, 4, side_white, 1'b0);
      clear_board();
      place(3, 5, w_king);
      check_single(3, 4, side_white, 1'b1);
      clear_board();
      place(4, 4, b_king);
      check_single(3, 4, side_black, 1'b1);
      clear_board();
      place(2, 3, w_pawn);
      check_single(3, 4, side_white, 1'b1);
      clear_board();
      place(4, 3, w_pawn);
      check_single(3, 4, side_white, 1'b0);
      clear_board();
      place(4, 5, b_pawn);
      check_single(3, 4, side_black, 1'b1);
      clear_board();
      place(2, 5, b_pawn);
      check_single(3, 4, side_black, 1'b0);
      // edge columns
      clear_board();
      place(2, 0, w_pawn);
      check_single(3, 1, side_white, 1'b1);
      clear_board();
      place(2, 6, w_pawn);
      check_single(3, 7, side_white, 1'b1);
      clear_board();
      place(5, 1, b_pawn);
      check_single(4, 0, side_black, 1'b1);
      clear_board();
      place(2, 1, b_knight);
      check_single(0, 0, side_black, 1'b1);
      clear_board();
      place(5, 6, w_knight);
      check_single(7, 7, side_white, 1'b1);
      // index neighbour across the board edge
      clear_board();
      place(2, 7, w_king);
      check_single(3, 0, side_white, 1'b0);
   endtask

   task automatic test_own_target();
      clear_board();
      place(3, 4, w_knight);
      place(3, 0, w_rook);
      place(2, 3, w_pawn);
      check_single(3, 4, side_white, 1'b0);
      place(7, 4, b_queen);
      check_single(3, 4, side_black, 1'b1);
   endtask

   task automatic test_streaming();
      board_t  b;
      square_t t;
      side_e   s;
      for (int n = 0; n < STREAM_QUERIES; n++)
      begin
         for (int i = 0; i < `BOARD_SQUARES; i++)
         begin
            if (({$random(seed)} % 8) < 3)
               b[i] = PIECE_SET[{$random(seed)} % 12];
            else
               b[i] = empty_sq;
         end
         t = square_t'({$random(seed)} % `BOARD_SQUARES);
         s = ($random(seed) & 1) ? side_black : side_white;
         send_query(b, t, s);
      end
      @(negedge clk);
      query_i.valid = 1'b0;
      while (answers_seen != queries_sent)
         @(negedge clk);
   endtask

   initial
   begin
      seed           = 37599;
      clk            = 1'b0;
      arst_n_i       = 1'b0;
      queries_sent   = 0;
      answers_seen   = 0;
      clear_board();
      query_i.valid  = 1'b0;
      query_i.board  = bd;
      query_i.target = '0;
      query_i.side   = side_white;
      test_reset_idle();
      test_sliders();
      test_leapers();
      test_own_target();
      test_streaming();
      $display("Test passed");
      $finish;
   end

endmodule

// File: build.f
+incdir+include
design/attack_pkg.sv
design/square_classifier.sv
design/ray_scanner.sv
design/leaper_checker.sv
design/attack_merge.sv
design/square_attack_top.sv
tests/tb_square_attack.sv

// File: run.sh
#!/bin/sh
# builds the attack detector testbench with Verilator and runs it

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing -Wno-fatal -f build.f --top-module tb_square_attack \
   -Mdir "$OBJ" -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

"./$OBJ/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Test passed" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
